// File: common/clock_io_defs.svh
`ifndef CLOCK_IO_DEFS_SVH
`define CLOCK_IO_DEFS_SVH

// Display write ports
`define PORT_SECONDS     8'd2
`define PORT_MINUTES     8'd3
`define PORT_HOURS       8'd4

// RTC register ports
`define PORT_RTC_ADDR    8'd12
`define PORT_RTC_CMD     8'd13
`define PORT_RTC_WDATA   8'd15

// RTC read-only ports
`define PORT_RTC_STATUS  8'd1
`define PORT_RTC_RDATA   8'd5

// Keyboard read ports, key data shares its number with minutes
`define PORT_KEY_DATA    8'd3
`define PORT_KEY_STATUS  8'd14

// Clock cycles per RTC bus phase
`define RTC_PHASE_CYCLES 4

// Scan-code queue entries, also the initial credit count
`define KEY_QUEUE_DEPTH  4

`endif

// File: common/clock_io_pkg.sv
`default_nettype none

package clock_io_pkg;

  //////////////////////////////////////////////////////////////////////
  // Processor port bus
  //////////////////////////////////////////////////////////////////////

  // Strobe-style port bus, one strobe per access
  typedef struct packed {
    logic [7:0] port_id;
    logic [7:0] out_port;
    logic       write_strobe;
    logic       read_strobe;
  } port_bus_t;

  //////////////////////////////////////////////////////////////////////
  // RTC transfer handshake
  //////////////////////////////////////////////////////////////////////

  // One transfer request, start is a single-cycle pulse
  typedef struct packed {
    logic       start;
    logic       is_read;
    logic [7:0] addr;
    logic [7:0] wdata;
  } rtc_req_t;

  // Done pulses once at the end of recovery
  typedef struct packed {
    logic       done;
    logic [7:0] rdata;
  } rtc_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Display and keyboard status
  //////////////////////////////////////////////////////////////////////

  // Time shown by the display, raw bytes from the processor
  typedef struct packed {
    logic [7:0] hours;
    logic [7:0] minutes;
    logic [7:0] seconds;
  } time_disp_t;

  // Key status byte as read on the key status port
  typedef struct packed {
    logic       not_empty;
    logic       overflow;
    logic [2:0] reserved;
    // Entries in the queue
    logic [2:0] count;
  } key_status_t;

endpackage

`default_nettype wire

// File: rtc_port/rtc_bus_sequencer.sv
`default_nettype none

`include "clock_io_defs.svh"

module rtc_bus_sequencer (
  input  wire                      clk,
  input  wire                      reset,
  input  wire clock_io_pkg::rtc_req_t req,
  output clock_io_pkg::rtc_rsp_t   rsp,
  output logic                     active,
  output logic                     ad_n,
  output logic                     cs_n,
  output logic                     rd_n,
  output logic                     wr_n,
  inout  wire  [7:0]               rtc_bus
);

  localparam int PHASE_CYCLES = `RTC_PHASE_CYCLES;
  localparam int CNT_W        = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_ADDR_SETUP,
    PH_ADDR_STROBE,
    PH_DATA_STROBE,
    PH_RECOVERY
  } phase_e;

  phase_e           phase;
  logic [CNT_W-1:0] cnt;
  logic             last_cycle;
  logic             is_read_q;
  logic [7:0]       addr_q;
  logic [7:0]       wdata_q;
  logic [7:0]       rdata_q;
  logic             bus_oe;
  logic [7:0]       bus_out;

  assign last_cycle = (cnt == CNT_W'(PHASE_CYCLES - 1));

  //////////////////////////////////////////////////////////////////////
  // Phase FSM and cycle counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end else if (phase == PH_IDLE) begin
      cnt <= '0;
      if (req.start) begin
        phase <= PH_ADDR_SETUP;
      end
    end else if (last_cycle) begin
      cnt <= '0;
      case (phase)
        PH_ADDR_SETUP:  phase <= PH_ADDR_STROBE;
        PH_ADDR_STROBE: phase <= PH_DATA_STROBE;
        PH_DATA_STROBE: phase <= PH_RECOVERY;
        default:        phase <= PH_IDLE;
      endcase
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Transfer fields held for the whole transfer
  always_ff @(posedge clk) begin
    if (phase == PH_IDLE && req.start) begin
      is_read_q <= req.is_read;
      addr_q    <= req.addr;
      wdata_q   <= req.wdata;
    end
    // Sample the chip on the last data strobe cycle
    if (phase == PH_DATA_STROBE && last_cycle && is_read_q) begin
      rdata_q <= rtc_bus;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus line decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cs_n    = 1'b1;
    ad_n    = 1'b1;
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    bus_oe  = 1'b0;
    bus_out = addr_q;
    case (phase)
      PH_ADDR_SETUP: begin
        cs_n   = 1'b0;
        ad_n   = 1'b0;
        bus_oe = 1'b1;
      end
      PH_ADDR_STROBE: begin
        cs_n   = 1'b0;
        ad_n   = 1'b0;
        wr_n   = 1'b0;
        bus_oe = 1'b1;
      end
      PH_DATA_STROBE: begin
        cs_n = 1'b0;
        // Read leaves the bus to the chip
        if (is_read_q) begin
          rd_n = 1'b0;
        end else begin
          wr_n    = 1'b0;
          bus_oe  = 1'b1;
          bus_out = wdata_q;
        end
      end
      default: ;
    endcase
  end

  assign rtc_bus = bus_oe ? bus_out : 8'hzz;

  assign active    = (phase != PH_IDLE);
  assign rsp.done  = (phase == PH_RECOVERY) && last_cycle;
  assign rsp.rdata = rdata_q;

  // Requester must hold off while a transfer runs
  no_start_while_active : assert property (@(posedge clk) disable iff (reset)
    req.start |-> !active);

endmodule

`default_nettype wire

// File: rtc_port/rtc_port.sv
`default_nettype none

`include "clock_io_defs.svh"

module rtc_port (
  input  wire                     clk,
  input  wire                     reset,
  input  wire clock_io_pkg::port_bus_t port_bus,
  input  wire                     irq_n,
  output logic [7:0]              status_byte,
  output logic [7:0]              rdata_byte,
  output wire                     ad_n,
  output wire                     cs_n,
  output wire                     rd_n,
  output wire                     wr_n,
  inout  wire  [7:0]              rtc_bus
);
  import clock_io_pkg::*;

  rtc_req_t   req;
  rtc_rsp_t   rsp;
  logic [7:0] addr_q;
  logic [7:0] wdata_q;
  logic       busy;
  logic       seq_active;
  logic       irq_meta;
  logic       irq_sync;
  logic       irq_prev;
  logic       alarm;
  logic       status_read;

  //////////////////////////////////////////////////////////////////////
  // Processor-side registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (port_bus.write_strobe && port_bus.port_id == `PORT_RTC_ADDR) begin
      addr_q <= port_bus.out_port;
    end
    if (port_bus.write_strobe && port_bus.port_id == `PORT_RTC_WDATA) begin
      wdata_q <= port_bus.out_port;
    end
    // Capture the byte returned by a read transfer
    if (rsp.done) begin
      rdata_byte <= rsp.rdata;
    end
  end

  // Command write starts a transfer unless one is running
  assign req.start   = port_bus.write_strobe && port_bus.port_id == `PORT_RTC_CMD && !busy;
  assign req.is_read = port_bus.out_port[0];
  assign req.addr    = addr_q;
  assign req.wdata   = wdata_q;

  // Busy from the command edge up to the edge after done
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (req.start) begin
      busy <= 1'b1;
    end else if (rsp.done) begin
      busy <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Alarm latch
  //////////////////////////////////////////////////////////////////////

  assign status_read = port_bus.read_strobe && port_bus.port_id == `PORT_RTC_STATUS;

  // IRQ idles high, two flops then edge detect
  always_ff @(posedge clk) begin
    if (reset) begin
      irq_meta <= 1'b1;
      irq_sync <= 1'b1;
      irq_prev <= 1'b1;
      alarm    <= 1'b0;
    end else begin
      irq_meta <= irq_n;
      irq_sync <= irq_meta;
      irq_prev <= irq_sync;
      // New IRQ assertion wins over a status read in the same cycle
      if (irq_prev && !irq_sync) begin
        alarm <= 1'b1;
      end else if (status_read) begin
        alarm <= 1'b0;
      end
    end
  end

  // Bit 0 busy, bit 1 alarm
  assign status_byte = {6'b000000, alarm, busy};

  rtc_bus_sequencer i_sequencer (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .active  (seq_active),
    .ad_n    (ad_n),
    .cs_n    (cs_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .rtc_bus (rtc_bus)
  );

  // Status busy flag tracks the sequencer exactly
  busy_matches_active : assert property (@(posedge clk) disable iff (reset)
    busy == seq_active);

endmodule

`default_nettype wire

// File: keyboard/ps2_receiver.sv
`default_nettype none

`include "clock_io_defs.svh"

module ps2_receiver (
  input  wire        clk,
  input  wire        reset,
  input  wire        ps2c,
  input  wire        ps2d,
  input  wire        credit_return,
  input  wire        clear_overflow,
  output logic       push,
  output logic [7:0] code,
  output logic       overflow
);

  localparam int DEPTH  = `KEY_QUEUE_DEPTH;
  localparam int CRED_W = $clog2(DEPTH + 1);

  logic              c_meta;
  logic              c_sync;
  logic              c_filt;
  logic              d_meta;
  logic              d_sync;
  logic              fall;
  logic [9:0]        shift_q;
  logic [3:0]        bit_cnt;
  logic              frame_good;
  logic              take;
  logic [CRED_W-1:0] credits;

  //////////////////////////////////////////////////////////////////////
  // Line sync and clock filter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      c_meta <= 1'b1;
      c_sync <= 1'b1;
      c_filt <= 1'b1;
      d_meta <= 1'b1;
      d_sync <= 1'b1;
    end else begin
      c_meta <= ps2c;
      c_sync <= c_meta;
      d_meta <= ps2d;
      d_sync <= d_meta;
      // Level moves only on two agreeing samples
      if (c_meta == c_sync) begin
        c_filt <= c_sync;
      end
    end
  end

  assign fall = c_filt && !c_sync && !c_meta;

  //////////////////////////////////////////////////////////////////////
  // Framing
  //////////////////////////////////////////////////////////////////////

  // LSB first, start lands in bit 0 and parity in bit 9
  always_ff @(posedge clk) begin
    if (fall) begin
      shift_q <= {d_sync, shift_q[9:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt <= '0;
    end else if (fall) begin
      bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
    end
  end

  // Stop bit is the live sample, odd parity over data and parity
  assign frame_good = fall && bit_cnt == 4'd10 && !shift_q[0] && d_sync && ^shift_q[9:1];
  assign take       = frame_good && credits != '0;

  //////////////////////////////////////////////////////////////////////
  // Credits and push
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      push     <= 1'b0;
      overflow <= 1'b0;
      credits  <= CRED_W'(DEPTH);
    end else begin
      push    <= take;
      credits <= credits + CRED_W'(credit_return) - CRED_W'(take);
      if (frame_good && credits == '0) begin
        overflow <= 1'b1;
      end else if (clear_overflow) begin
        overflow <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      code <= shift_q[8:1];
    end
  end

  // Returns from the queue never outrun pushes so credits stay within depth
  credits_in_range : assert property (@(posedge clk) disable iff (reset)
    credits <= CRED_W'(DEPTH));

endmodule

`default_nettype wire

// File: keyboard/key_queue.sv
`default_nettype none

`include "clock_io_defs.svh"

module key_queue (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        push,
  input  wire  [7:0]                 code,
  input  wire                        pop,
  input  wire                        overflow,
  output logic [7:0]                 head,
  output clock_io_pkg::key_status_t  status,
  output logic                       credit_return
);

  localparam int DEPTH = `KEY_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [7:0]       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // Pop of an empty queue is a no-op
  assign do_pop = pop && count != '0;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= code;
    end
  end

  // Pointers wrap at depth, no power of two needed
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= do_pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign head = mem[rd_ptr];

  assign status.not_empty = (count != '0);
  assign status.overflow  = overflow;
  assign status.reserved  = 3'b000;
  assign status.count     = 3'(count);

  // Credit loop keeps the queue from ever filling past depth
  no_queue_overflow : assert property (@(posedge clk) disable iff (reset)
    push |-> (count < CNT_W'(DEPTH)) || do_pop);

endmodule

`default_nettype wire

// File: design/io_port_hub.sv
`default_nettype none

`include "clock_io_defs.svh"

module io_port_hub (
  input  wire                         clk,
  input  wire                         reset,
  input  wire clock_io_pkg::port_bus_t port_bus,
  input  wire                         irq_n,
  input  wire                         ps2c,
  input  wire                         ps2d,
  output logic [7:0]                  in_port,
  output clock_io_pkg::time_disp_t    time_disp,
  output wire                         ad_n,
  output wire                         cs_n,
  output wire                         rd_n,
  output wire                         wr_n,
  inout  wire  [7:0]                  rtc_bus
);
  import clock_io_pkg::*;

  logic [7:0]  rtc_status;
  logic [7:0]  rtc_rdata;
  logic        key_push;
  logic [7:0]  key_code;
  logic        key_overflow;
  logic        key_pop;
  logic        key_clear;
  logic        key_credit;
  logic [7:0]  key_head;
  key_status_t key_status;

  //////////////////////////////////////////////////////////////////////
  // Display registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      time_disp <= '0;
    end else if (port_bus.write_strobe) begin
      case (port_bus.port_id)
        `PORT_SECONDS: time_disp.seconds <= port_bus.out_port;
        `PORT_MINUTES: time_disp.minutes <= port_bus.out_port;
        `PORT_HOURS:   time_disp.hours   <= port_bus.out_port;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Read strobes with side effects
  assign key_pop   = port_bus.read_strobe && port_bus.port_id == `PORT_KEY_DATA;
  assign key_clear = port_bus.read_strobe && port_bus.port_id == `PORT_KEY_STATUS;

  // Mux on port number alone, unmapped reads give zero
  always_comb begin
    case (port_bus.port_id)
      `PORT_RTC_STATUS: in_port = rtc_status;
      `PORT_RTC_RDATA:  in_port = rtc_rdata;
      `PORT_KEY_DATA:   in_port = key_status.not_empty ? key_head : 8'h00;
      `PORT_KEY_STATUS: in_port = key_status;
      default:          in_port = 8'h00;
    endcase
  end

  rtc_port i_rtc_port (
    .clk         (clk),
    .reset       (reset),
    .port_bus    (port_bus),
    .irq_n       (irq_n),
    .status_byte (rtc_status),
    .rdata_byte  (rtc_rdata),
    .ad_n        (ad_n),
    .cs_n        (cs_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .rtc_bus     (rtc_bus)
  );

  ps2_receiver i_ps2_receiver (
    .clk            (clk),
    .reset          (reset),
    .ps2c           (ps2c),
    .ps2d           (ps2d),
    .credit_return  (key_credit),
    .clear_overflow (key_clear),
    .push           (key_push),
    .code           (key_code),
    .overflow       (key_overflow)
  );

  key_queue i_key_queue (
    .clk           (clk),
    .reset         (reset),
    .push          (key_push),
    .code          (key_code),
    .pop           (key_pop),
    .overflow      (key_overflow),
    .head          (key_head),
    .status        (key_status),
    .credit_return (key_credit)
  );

endmodule

`default_nettype wire

// File: dv/tb_rtc_model.sv
`default_nettype none

module tb_rtc_model (
  input  wire       clk,
  input  wire       ad_n,
  input  wire       cs_n,
  input  wire       rd_n,
  input  wire       wr_n,
  inout  wire [7:0] rtc_bus,
  // Backdoor load port for test setup
  input  wire       load_en,
  input  wire [3:0] load_addr,
  input  wire [7:0] load_data
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] regs [16];
  logic [3:0] addr_q;
  logic       drive;

  // Known contents before any transfer, every address distinct
  initial begin
    addr_q = 4'h0;
    for (int i = 0; i < 16; i++) begin
      regs[i] = {~i[3:0], i[3:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Chip side of the multiplexed bus
  //////////////////////////////////////////////////////////////////////

  // Lines sampled mid-cycle, away from the controller's edges
  always @(negedge clk) begin
    if (!cs_n && !wr_n) begin
      // AD low marks the address half of the transfer
      if (!ad_n) begin
        addr_q <= rtc_bus[3:0];
      end else begin
        regs[addr_q] <= rtc_bus;
      end
    end
    if (load_en) begin
      regs[load_addr] <= load_data;
    end
  end

  // Chip drives data only during the read strobe
  assign drive   = !cs_n && ad_n && !rd_n;
  assign rtc_bus = drive ? regs[addr_q] : 8'hzz;

endmodule

`default_nettype wire

// File: dv/tb_clock_io.sv
`default_nettype none

`include "clock_io_defs.svh"

module tb_clock_io;
  timeunit 1ns;
  timeprecision 1ps;
  import clock_io_pkg::*;

  // Nine PS/2 frames of about 200 cycles plus two RTC transfers,
  // roughly 2500 cycles, so the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int POLL_LIMIT     = 200;
  // System clocks per PS/2 clock half period
  localparam int PS2_HALF       = 8;

  logic        clk;
  logic        reset;
  port_bus_t   port_bus;
  logic        irq_n;
  logic        ps2c;
  logic        ps2d;
  logic [7:0]  in_port;
  time_disp_t  time_disp;
  wire         ad_n;
  wire         cs_n;
  wire         rd_n;
  wire         wr_n;
  wire  [7:0]  rtc_bus;
  logic        load_en;
  logic [3:0]  load_addr;
  logic [7:0]  load_data;
  logic [31:0] rng_state;
  int          cycle_count = 0;
  int          check_count = 0;
  int          mismatch_count = 0;
  int          failure_count = 0;

  io_port_hub i_dut (
    .clk       (clk),
    .reset     (reset),
    .port_bus  (port_bus),
    .irq_n     (irq_n),
    .ps2c      (ps2c),
    .ps2d      (ps2d),
    .in_port   (in_port),
    .time_disp (time_disp),
    .ad_n      (ad_n),
    .cs_n      (cs_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .rtc_bus   (rtc_bus)
  );

  tb_rtc_model i_rtc_model (
    .clk       (clk),
    .ad_n      (ad_n),
    .cs_n      (cs_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .rtc_bus   (rtc_bus),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_time(input time_disp_t got, input time_disp_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %h:%h:%h expected %h:%h:%h", $time, what,
               got.hours, got.minutes, got.seconds, exp.hours, exp.minutes, exp.seconds);
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_key_status(input key_status_t got, input key_status_t exp,
                                  input string what);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got ne=%b ov=%b cnt=%0d expected ne=%b ov=%b cnt=%0d",
               $time, what, got.not_empty, got.overflow, got.count,
               exp.not_empty, exp.overflow, exp.count);
    end
  endtask

  function automatic key_status_t make_key_status(input logic ne, input logic ov,
                                                  input logic [2:0] cnt);
    key_status_t s;
    s = '0;
    s.not_empty = ne;
    s.overflow  = ov;
    s.count     = cnt;
    return s;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Port bus and line drivers
  //////////////////////////////////////////////////////////////////////

  // Strobe is seen by the DUT on the edge where it is dropped
  task automatic port_write(input logic [7:0] port, input logic [7:0] data);
    @(posedge clk);
    port_bus <= '{port_id: port, out_port: data, write_strobe: 1'b1, read_strobe: 1'b0};
    @(posedge clk);
    port_bus <= '0;
  endtask

  // in_port sampled mid-cycle while the strobe is up
  task automatic port_read(input logic [7:0] port, output logic [7:0] data);
    @(posedge clk);
    port_bus <= '{port_id: port, out_port: 8'h00, write_strobe: 1'b0, read_strobe: 1'b1};
    @(negedge clk);
    data = in_port;
    @(posedge clk);
    port_bus <= '0;
  endtask

  task automatic preload_rtc(input logic [3:0] addr, input logic [7:0] data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= addr;
    load_data <= data;
    @(posedge clk);
    load_en   <= 1'b0;
  endtask

  task automatic wait_rtc_idle();
    logic [7:0] status;
    int         polls;
    status = 8'h01;
    polls  = 0;
    while (status[0] && polls < POLL_LIMIT) begin
      port_read(`PORT_RTC_STATUS, status);
      polls++;
    end
    if (status[0]) begin
      failure_count++;
      $display("RTC busy flag never cleared after %0d status reads", polls);
    end
  endtask

  // Polls until the expected status shows, then compares the last read
  task automatic wait_key_status(input key_status_t exp, input string what);
    logic [7:0] got;
    int         polls;
    polls = 0;
    do begin
      port_read(`PORT_KEY_STATUS, got);
      polls++;
    end while (got != exp && polls < POLL_LIMIT);
    check_key_status(got, exp, what);
  endtask

  // Data changes while PS/2 clock is high, sampled on its fall
  task automatic ps2_bit(input logic b);
    @(posedge clk);
    ps2d <= b;
    repeat (PS2_HALF / 2) @(posedge clk);
    ps2c <= 1'b0;
    repeat (PS2_HALF) @(posedge clk);
    ps2c <= 1'b1;
    repeat (PS2_HALF / 2) @(posedge clk);
  endtask

  task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    // Stop, odd parity, data LSB first, start
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_bit(frame[i]);
    end
    repeat (2 * PS2_HALF) @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [7:0] data;
    @(negedge clk);
    check_time(time_disp, '0, "display after reset");
    check_byte({4'h0, ad_n, cs_n, rd_n, wr_n}, 8'h0f, "RTC control lines after reset");
    port_read(`PORT_RTC_STATUS, data);
    check_byte(data, 8'h00, "RTC status after reset");
    port_read(`PORT_KEY_STATUS, data);
    check_key_status(data, make_key_status(1'b0, 1'b0, 3'd0), "key status after reset");
  endtask

  task automatic test_display_writes();
    time_disp_t exp;
    exp = '0;
    port_write(`PORT_SECONDS, 8'h45);
    exp.seconds = 8'h45;
    @(negedge clk);
    check_time(time_disp, exp, "seconds write");
    port_write(`PORT_MINUTES, 8'h30);
    exp.minutes = 8'h30;
    @(negedge clk);
    check_time(time_disp, exp, "minutes write");
    port_write(`PORT_HOURS, 8'h12);
    exp.hours = 8'h12;
    @(negedge clk);
    check_time(time_disp, exp, "hours write");
    // Unmapped and non-display ports
    port_write(8'd7, 8'hff);
    port_write(`PORT_RTC_ADDR, 8'h00);
    @(negedge clk);
    check_time(time_disp, exp, "display after other port writes");
  endtask

  task automatic test_rtc_write();
    logic [7:0] status;
    port_write(`PORT_RTC_ADDR, 8'h0a);
    port_write(`PORT_RTC_WDATA, 8'h5c);
    port_write(`PORT_RTC_CMD, 8'h00);
    port_read(`PORT_RTC_STATUS, status);
    check_byte(status & 8'h01, 8'h01, "busy after write command");
    wait_rtc_idle();
    check_byte(i_rtc_model.regs[4'ha], 8'h5c, "RTC register after write");
  endtask

  task automatic test_rtc_read();
    logic [7:0] data;
    int         polls;
    preload_rtc(4'h3, 8'ha7);
    port_write(`PORT_RTC_ADDR, 8'h03);
    port_write(`PORT_RTC_CMD, 8'h01);
    wait_rtc_idle();
    port_read(`PORT_RTC_RDATA, data);
    check_byte(data, 8'ha7, "RTC read data");
    // Alarm, the read that sees it also clears it
    @(posedge clk);
    irq_n <= 1'b0;
    data  = 8'h00;
    polls = 0;
    while (!data[1] && polls < POLL_LIMIT) begin
      port_read(`PORT_RTC_STATUS, data);
      polls++;
    end
    if (!data[1]) begin
      failure_count++;
      $display("Alarm bit never set after the IRQ line went low");
    end
    port_read(`PORT_RTC_STATUS, data);
    check_byte(data, 8'h00, "RTC status after alarm read");
    @(posedge clk);
    irq_n <= 1'b1;
  endtask

  task automatic test_key_order();
    logic [7:0] codes [3];
    logic [7:0] data;
    for (int i = 0; i < 3; i++) begin
      rng_state = xorshift32(rng_state);
      codes[i]  = rng_state[7:0];
      send_ps2(codes[i], 1'b0);
    end
    send_ps2(8'h5a, 1'b1);
    wait_key_status(make_key_status(1'b1, 1'b0, 3'd3), "key status after three codes");
    for (int i = 0; i < 3; i++) begin
      port_read(`PORT_KEY_DATA, data);
      check_byte(data, codes[i], "key code order");
    end
    port_read(`PORT_KEY_STATUS, data);
    check_key_status(data, make_key_status(1'b0, 1'b0, 3'd0), "key status after drain");
  endtask

  task automatic test_credit_overflow();
    logic [7:0] codes [5];
    logic [7:0] data;
    for (int i = 0; i < 5; i++) begin
      rng_state = xorshift32(rng_state);
      codes[i]  = rng_state[7:0];
      send_ps2(codes[i], 1'b0);
    end
    wait_key_status(make_key_status(1'b1, 1'b1, 3'd4), "key status with overflow");
    port_read(`PORT_KEY_STATUS, data);
    check_key_status(data, make_key_status(1'b1, 1'b0, 3'd4), "overflow after status read");
    for (int i = 0; i < 4; i++) begin
      port_read(`PORT_KEY_DATA, data);
      check_byte(data, codes[i], "key code before overflow");
    end
    port_read(`PORT_KEY_STATUS, data);
    check_key_status(data, make_key_status(1'b0, 1'b0, 3'd0), "key status after drain");
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    port_bus  = '0;
    irq_n     = 1'b1;
    ps2c      = 1'b1;
    ps2d      = 1'b1;
    load_en   = 1'b0;
    load_addr = 4'h0;
    load_data = 8'h00;
    rng_state = 32'h782253a9;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_display_writes();
    test_rtc_write();
    test_rtc_read();
    test_key_order();
    test_credit_overflow();
    $display("%0d checks, %0d mismatches, %0d other errors",
             check_count, mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/clock_io_pkg.sv
rtc_port/rtc_bus_sequencer.sv
rtc_port/rtc_port.sv
keyboard/ps2_receiver.sv
keyboard/key_queue.sv
design/io_port_hub.sv
dv/tb_rtc_model.sv
dv/tb_clock_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_clock_io \
  -f all.f \
  -o tb_clock_io

./obj_dir/tb_clock_io | tee sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
